/* verilog/flash_bus_pkg.sv */
/*
 * Flash bus scheduler definitions: widths, host and controller opcodes,
 * chip-state codes and scheduler state codes
 */
package flash_bus_pkg;

	localparam int NUM_CHIPS    = 4;
	localparam int CHIP_W       = 2;
	localparam int CMD_W        = 72;
	localparam int TAG_W        = 8;
	localparam int SIZE_W       = 10;
	localparam int HOP_W        = 8;
	localparam int BUS_ADDR_W   = 46;
	localparam int FLASH_ADDR_W = 40;
	localparam int LEN_W        = 15;
	localparam int RSLT_W       = 26;
	localparam int CS_W         = 5;
	localparam int CTRL_OP_W    = 5;
	localparam int STAMP_W      = 36;
	localparam int SUM_W        = 32;

	// Host opcodes carried in the command word
	localparam logic [HOP_W-1:0] HOP_READ    = 8'd1;
	localparam logic [HOP_W-1:0] HOP_PROGRAM = 8'd2;
	localparam logic [HOP_W-1:0] HOP_ERASE   = 8'd3;

	// Bus controller opcodes
	localparam logic [CTRL_OP_W-1:0] OP_READSTATUS     = 5'd1;
	localparam logic [CTRL_OP_W-1:0] OP_JUSTREADSTATUS = 5'd2;
	localparam logic [CTRL_OP_W-1:0] OP_STARTREAD      = 5'd3;
	localparam logic [CTRL_OP_W-1:0] OP_COMPLETEREAD   = 5'd4;
	localparam logic [CTRL_OP_W-1:0] OP_PROGRAM        = 5'd5;
	localparam logic [CTRL_OP_W-1:0] OP_ERASE          = 5'd6;

	// Per-chip progress through a host operation
	localparam logic [CS_W-1:0] CS_IDLE               = 5'd0;
	localparam logic [CS_W-1:0] CS_READ_START_PENDING = 5'd1;
	localparam logic [CS_W-1:0] CS_READ_DATA_PENDING  = 5'd2;
	localparam logic [CS_W-1:0] CS_READ_DATA_DONE     = 5'd3;
	localparam logic [CS_W-1:0] CS_WRITE_DATA_PENDING = 5'd4;
	localparam logic [CS_W-1:0] CS_WRITE_DATA_ONBUS   = 5'd5;
	localparam logic [CS_W-1:0] CS_WRITE_DATA_DONE    = 5'd6;
	localparam logic [CS_W-1:0] CS_ERASE_PENDING      = 5'd7;
	localparam logic [CS_W-1:0] CS_ERASE_ONBUS        = 5'd8;
	localparam logic [CS_W-1:0] CS_ERASE_DONE         = 5'd9;

	// Scheduler FSM states
	localparam int ST_W = 4;
	localparam logic [ST_W-1:0] ST_IDLE        = 4'd0;
	localparam logic [ST_W-1:0] ST_NEW_RQST    = 4'd1;
	localparam logic [ST_W-1:0] ST_VISIT_WAIT  = 4'd2;
	localparam logic [ST_W-1:0] ST_WAIT_CTRL   = 4'd3;
	localparam logic [ST_W-1:0] ST_CHECK_READY = 4'd4;
	localparam logic [ST_W-1:0] ST_DO_BUS_OP   = 4'd5;
	localparam logic [ST_W-1:0] ST_NEW_RSLT_0  = 4'd6;
	localparam logic [ST_W-1:0] ST_NEW_RSLT_1  = 4'd7;
	localparam logic [ST_W-1:0] ST_SWITCH      = 4'd8;

endpackage

/* verilog/chip_scoreboard.sv */
/*
 * Chip scoreboard: one entry per chip with the command in flight,
 * read back one cycle after the index is presented
 */
`timescale 1ns/1ps

module chip_scoreboard
	import flash_bus_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic [CHIP_W-1:0]     i_index,
	input  logic                  i_we,
	input  logic [TAG_W-1:0]      i_tag,
	input  logic [HOP_W-1:0]      i_hop,
	input  logic [CS_W-1:0]       i_cs,
	input  logic [SIZE_W-1:0]     i_size,
	input  logic [BUS_ADDR_W-1:0] i_addr,
	input  logic                  i_sent_status,
	input  logic [STAMP_W-1:0]    i_stamp,
	output logic [TAG_W-1:0]      o_tag,
	output logic [HOP_W-1:0]      o_hop,
	output logic [CS_W-1:0]       o_cs,
	output logic [SIZE_W-1:0]     o_size,
	output logic [BUS_ADDR_W-1:0] o_addr,
	output logic                  o_sent_status,
	output logic [STAMP_W-1:0]    o_stamp
);

	logic [TAG_W-1:0]      tag_mem   [NUM_CHIPS];
	logic [HOP_W-1:0]      hop_mem   [NUM_CHIPS];
	logic [CS_W-1:0]       cs_mem    [NUM_CHIPS];
	logic [SIZE_W-1:0]     size_mem  [NUM_CHIPS];
	logic [BUS_ADDR_W-1:0] addr_mem  [NUM_CHIPS];
	logic                  sent_mem  [NUM_CHIPS];
	logic [STAMP_W-1:0]    stamp_mem [NUM_CHIPS];

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			for (int i = 0; i < NUM_CHIPS; i++) begin
				tag_mem[i]   <= '0;
				hop_mem[i]   <= '0;
				cs_mem[i]    <= CS_IDLE;
				size_mem[i]  <= '0;
				addr_mem[i]  <= '0;
				sent_mem[i]  <= 1'b0;
				stamp_mem[i] <= '0;
			end
			o_tag         <= '0;
			o_hop         <= '0;
			o_cs          <= CS_IDLE;
			o_size        <= '0;
			o_addr        <= '0;
			o_sent_status <= 1'b0;
			o_stamp       <= '0;
		end else begin
			if (i_we) begin
				tag_mem[i_index]   <= i_tag;
				hop_mem[i_index]   <= i_hop;
				cs_mem[i_index]    <= i_cs;
				size_mem[i_index]  <= i_size;
				addr_mem[i_index]  <= i_addr;
				sent_mem[i_index]  <= i_sent_status;
				stamp_mem[i_index] <= i_stamp;
			end
			// Read returns the entry as it was before any write this cycle
			o_tag         <= tag_mem[i_index];
			o_hop         <= hop_mem[i_index];
			o_cs          <= cs_mem[i_index];
			o_size        <= size_mem[i_index];
			o_addr        <= addr_mem[i_index];
			o_sent_status <= sent_mem[i_index];
			o_stamp       <= stamp_mem[i_index];
		end
	end

endmodule

/* verilog/chip_op_table.sv */
/*
 * Chip operation table: first chip state for a host op, and the controller
 * opcode and following state for each chip state
 */
`timescale 1ns/1ps

module chip_op_table
	import flash_bus_pkg::*;
(
	input  logic [HOP_W-1:0]     i_cmd_hop,
	input  logic [CS_W-1:0]      i_cs,
	output logic [CS_W-1:0]      o_entry_cs,
	output logic [CTRL_OP_W-1:0] o_ctrl_op,
	output logic [CS_W-1:0]      o_next_cs,
	output logic                 o_issues,
	output logic                 o_done
);

	always_comb begin
		case (i_cmd_hop)
			HOP_READ:    o_entry_cs = CS_READ_START_PENDING;
			HOP_PROGRAM: o_entry_cs = CS_WRITE_DATA_PENDING;
			HOP_ERASE:   o_entry_cs = CS_ERASE_PENDING;
			default:     o_entry_cs = CS_IDLE;
		endcase
	end

	always_comb begin
		o_ctrl_op = '0;
		o_next_cs = CS_IDLE;
		o_issues  = 1'b0;
		o_done    = 1'b0;
		case (i_cs)
			CS_READ_START_PENDING: begin
				o_ctrl_op = OP_STARTREAD;
				o_next_cs = CS_READ_DATA_PENDING;
				o_issues  = 1'b1;
			end
			CS_READ_DATA_PENDING: begin
				o_ctrl_op = OP_COMPLETEREAD;
				o_next_cs = CS_READ_DATA_DONE;
				o_issues  = 1'b1;
			end
			CS_WRITE_DATA_PENDING: begin
				o_ctrl_op = OP_PROGRAM;
				o_next_cs = CS_WRITE_DATA_ONBUS;
				o_issues  = 1'b1;
			end
			CS_ERASE_PENDING: begin
				o_ctrl_op = OP_ERASE;
				o_next_cs = CS_ERASE_ONBUS;
				o_issues  = 1'b1;
			end
			// Chip went ready after program or erase, nothing on the bus
			CS_WRITE_DATA_ONBUS: o_next_cs = CS_WRITE_DATA_DONE;
			CS_ERASE_ONBUS:      o_next_cs = CS_ERASE_DONE;
			CS_READ_DATA_DONE,
			CS_WRITE_DATA_DONE,
			CS_ERASE_DONE:       o_done = 1'b1;
			default: ;
		endcase
	end

endmodule

/* verilog/cycle_profiler.sv */
/*
 * Cycle profiler: free-running cycle count, and the summed time between
 * two programmable chip states over all operations
 */
`timescale 1ns/1ps

module cycle_profiler
	import flash_bus_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_visit,
	input  logic [CS_W-1:0]    i_cs,
	input  logic [STAMP_W-1:0] i_stamp_rd,
	input  logic               i_cyclecount_reset,
	input  logic [7:0]         i_cyclecount_start,
	input  logic [7:0]         i_cyclecount_end,
	output logic [STAMP_W-1:0] o_stamp_wr,
	output logic [SUM_W-1:0]   o_cyclecount_sum
);

	logic [STAMP_W-1:0] sys_count;
	logic [STAMP_W-1:0] elapsed;
	logic               start_hit;
	logic               end_hit;

	// Code zero turns the window off
	assign start_hit = i_visit && (i_cyclecount_start[CS_W-1:0] != CS_IDLE) &&
	                   (i_cyclecount_start[CS_W-1:0] == i_cs);
	assign end_hit   = i_visit && (i_cyclecount_end[CS_W-1:0] != CS_IDLE) &&
	                   (i_cyclecount_end[CS_W-1:0] == i_cs);

	assign o_stamp_wr = start_hit ? sys_count : i_stamp_rd;
	assign elapsed    = sys_count - i_stamp_rd;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			sys_count        <= '0;
			o_cyclecount_sum <= '0;
		end else begin
			sys_count <= sys_count + 1'b1;
			if (i_cyclecount_reset)
				o_cyclecount_sum <= '0;
			else if (end_hit)
				o_cyclecount_sum <= o_cyclecount_sum + elapsed[SUM_W-1:0];
		end
	end

endmodule

/* verilog/bus_sched_fsm.sv */
/*
 * Flash bus scheduler FSM: takes commands from the dispatcher, visits active
 * chips round robin to poll or issue bus ops, and returns results
 */
`timescale 1ns/1ps

module bus_sched_fsm
	import flash_bus_pkg::*;
(
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_disp_cmd_req,
	input  logic [CMD_W-1:0]        i_disp_cmd_data,
	input  logic                    i_disp_rsp_ack,
	input  logic                    i_ctrl_busy,
	input  logic [NUM_CHIPS-1:0]    i_ctrl_chip_ready,
	input  logic [TAG_W-1:0]        i_sb_tag,
	input  logic [HOP_W-1:0]        i_sb_hop,
	input  logic [CS_W-1:0]         i_sb_cs,
	input  logic [SIZE_W-1:0]       i_sb_size,
	input  logic [BUS_ADDR_W-1:0]   i_sb_addr,
	input  logic                    i_sb_sent_status,
	input  logic [CS_W-1:0]         i_entry_cs,
	input  logic [CTRL_OP_W-1:0]    i_ctrl_op,
	input  logic [CS_W-1:0]         i_next_cs,
	input  logic                    i_cs_issues,
	input  logic                    i_cs_done,
	output logic                    o_disp_cmd_ack,
	output logic                    o_disp_rsp_req,
	output logic [RSLT_W-1:0]       o_disp_rsp_data,
	output logic [NUM_CHIPS-1:0]    o_disp_chip_active,
	output logic                    o_disp_wr_buffer_rsvd,
	output logic                    o_disp_rd_buffer_rsvd,
	output logic [CTRL_OP_W-1:0]    o_ctrl_operation,
	output logic [CHIP_W-1:0]       o_ctrl_chip,
	output logic [FLASH_ADDR_W-1:0] o_ctrl_addr,
	output logic [LEN_W-1:0]        o_ctrl_length,
	output logic                    o_ctrl_start,
	output logic [CHIP_W-1:0]       o_sb_index,
	output logic                    o_sb_we,
	output logic [TAG_W-1:0]        o_sb_tag,
	output logic [HOP_W-1:0]        o_sb_hop,
	output logic [CS_W-1:0]         o_sb_cs,
	output logic [SIZE_W-1:0]       o_sb_size,
	output logic [BUS_ADDR_W-1:0]   o_sb_addr,
	output logic                    o_sb_sent_status,
	output logic [HOP_W-1:0]        o_cmd_hop,
	output logic                    o_visit
);

	logic [ST_W-1:0]       state;
	logic [CHIP_W-1:0]     curr_chip;

	// Command captured at acceptance
	logic [TAG_W-1:0]      cmd_tag;
	logic [SIZE_W-1:0]     cmd_size;
	logic [HOP_W-1:0]      cmd_hop;
	logic [BUS_ADDR_W-1:0] cmd_addr;

	logic [CHIP_W-1:0]     cmd_chip;
	logic [CHIP_W-1:0]     sb_chip;

	assign cmd_chip = cmd_addr[FLASH_ADDR_W +: CHIP_W];
	assign sb_chip  = i_sb_addr[FLASH_ADDR_W +: CHIP_W];

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state                 <= ST_IDLE;
			curr_chip             <= '0;
			o_disp_cmd_ack        <= 1'b0;
			o_disp_rsp_req        <= 1'b0;
			o_disp_chip_active    <= '0;
			o_disp_wr_buffer_rsvd <= 1'b0;
			o_disp_rd_buffer_rsvd <= 1'b0;
		end else begin
			o_disp_cmd_ack <= 1'b0;
			case (state)
				ST_IDLE: begin
					// New commands take priority over visits
					if (i_disp_cmd_req) begin
						o_disp_cmd_ack <= 1'b1;
						state          <= ST_NEW_RQST;
					end else if (o_disp_chip_active[curr_chip]) begin
						state <= ST_VISIT_WAIT;
					end else begin
						curr_chip <= curr_chip + 1'b1;
					end
				end
				ST_NEW_RQST: begin
					o_disp_chip_active[cmd_chip] <= 1'b1;
					if (cmd_hop == HOP_READ)
						o_disp_rd_buffer_rsvd <= 1'b1;
					if (cmd_hop == HOP_PROGRAM)
						o_disp_wr_buffer_rsvd <= 1'b1;
					state <= ST_IDLE;
				end
				// Scoreboard read of the current chip is valid after this cycle
				ST_VISIT_WAIT: state <= ST_WAIT_CTRL;
				ST_WAIT_CTRL: begin
					if (!i_ctrl_busy)
						state <= ST_CHECK_READY;
				end
				ST_CHECK_READY: begin
					state <= i_ctrl_chip_ready[sb_chip] ? ST_DO_BUS_OP : ST_SWITCH;
				end
				ST_DO_BUS_OP: begin
					state <= i_cs_done ? ST_NEW_RSLT_0 : ST_SWITCH;
				end
				ST_NEW_RSLT_0: begin
					o_disp_rsp_req <= 1'b1;
					state          <= ST_NEW_RSLT_1;
				end
				ST_NEW_RSLT_1: begin
					if (i_disp_rsp_ack) begin
						o_disp_rsp_req                <= 1'b0;
						o_disp_chip_active[curr_chip] <= 1'b0;
						if (i_sb_hop == HOP_READ)
							o_disp_rd_buffer_rsvd <= 1'b0;
						if (i_sb_hop == HOP_PROGRAM)
							o_disp_wr_buffer_rsvd <= 1'b0;
						state <= ST_SWITCH;
					end
				end
				ST_SWITCH: begin
					curr_chip <= curr_chip + 1'b1;
					state     <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Command fields and result word
	always_ff @(posedge i_clk) begin
		if (state == ST_IDLE && i_disp_cmd_req) begin
			cmd_tag  <= i_disp_cmd_data[CMD_W-1 -: TAG_W];
			cmd_size <= i_disp_cmd_data[CMD_W-TAG_W-1 -: SIZE_W];
			cmd_hop  <= i_disp_cmd_data[BUS_ADDR_W +: HOP_W];
			cmd_addr <= i_disp_cmd_data[BUS_ADDR_W-1:0];
		end
		if (state == ST_NEW_RSLT_0)
			o_disp_rsp_data <= {i_sb_tag, i_sb_size, 8'd0};
	end

	// Scoreboard writes and controller issue
	always_comb begin
		o_sb_index       = curr_chip;
		o_sb_we          = 1'b0;
		o_sb_tag         = i_sb_tag;
		o_sb_hop         = i_sb_hop;
		o_sb_cs          = i_sb_cs;
		o_sb_size        = i_sb_size;
		o_sb_addr        = i_sb_addr;
		o_sb_sent_status = i_sb_sent_status;
		o_ctrl_operation = '0;
		o_ctrl_start     = 1'b0;
		case (state)
			ST_NEW_RQST: begin
				o_sb_index       = cmd_chip;
				o_sb_we          = 1'b1;
				o_sb_tag         = cmd_tag;
				o_sb_hop         = cmd_hop;
				o_sb_cs          = i_entry_cs;
				o_sb_size        = cmd_size;
				o_sb_addr        = cmd_addr;
				o_sb_sent_status = 1'b0;
			end
			ST_CHECK_READY: begin
				// Chip busy, poll its status and move on
				if (!i_ctrl_chip_ready[sb_chip]) begin
					o_ctrl_operation = i_sb_sent_status ? OP_JUSTREADSTATUS : OP_READSTATUS;
					o_ctrl_start     = 1'b1;
					o_sb_we          = 1'b1;
					o_sb_sent_status = 1'b1;
				end
			end
			ST_DO_BUS_OP: begin
				if (!i_cs_done) begin
					o_sb_we = 1'b1;
					o_sb_cs = i_next_cs;
					if (i_cs_issues) begin
						o_ctrl_operation = i_ctrl_op;
						o_ctrl_start     = 1'b1;
					end
				end
			end
			default: ;
		endcase
	end

	assign o_ctrl_chip   = sb_chip;
	assign o_ctrl_addr   = i_sb_addr[FLASH_ADDR_W-1:0];
	assign o_ctrl_length = {i_sb_size, 5'd0};
	assign o_cmd_hop     = cmd_hop;
	assign o_visit       = (state == ST_DO_BUS_OP);

endmodule

/* verilog/flash_bus_top.sv */
/*
 * Flash bus scheduler top level
 * Joins the scheduler FSM, chip scoreboard, operation table and cycle profiler
 */
`timescale 1ns/1ps

module flash_bus_top
	import flash_bus_pkg::*;
(
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_disp_cmd_req,
	input  logic [CMD_W-1:0]        i_disp_cmd_data,
	input  logic                    i_disp_rsp_ack,
	input  logic                    i_cyclecount_reset,
	input  logic [7:0]              i_cyclecount_start,
	input  logic [7:0]              i_cyclecount_end,
	input  logic                    i_ctrl_busy,
	input  logic [NUM_CHIPS-1:0]    i_ctrl_chip_ready,
	output logic                    o_disp_cmd_ack,
	output logic                    o_disp_rsp_req,
	output logic [RSLT_W-1:0]       o_disp_rsp_data,
	output logic [NUM_CHIPS-1:0]    o_disp_chip_active,
	output logic                    o_disp_wr_buffer_rsvd,
	output logic                    o_disp_rd_buffer_rsvd,
	output logic [SUM_W-1:0]        o_cyclecount_sum,
	output logic [CTRL_OP_W-1:0]    o_ctrl_operation,
	output logic [CHIP_W-1:0]       o_ctrl_chip,
	output logic [FLASH_ADDR_W-1:0] o_ctrl_addr,
	output logic [LEN_W-1:0]        o_ctrl_length,
	output logic                    o_ctrl_start
);

	// Scoreboard write side
	logic [CHIP_W-1:0]     sb_index;
	logic                  sb_we;
	logic [TAG_W-1:0]      sb_tag_wr;
	logic [HOP_W-1:0]      sb_hop_wr;
	logic [CS_W-1:0]       sb_cs_wr;
	logic [SIZE_W-1:0]     sb_size_wr;
	logic [BUS_ADDR_W-1:0] sb_addr_wr;
	logic                  sb_sent_wr;
	logic [STAMP_W-1:0]    stamp_wr;

	// Scoreboard read side
	logic [TAG_W-1:0]      sb_tag_rd;
	logic [HOP_W-1:0]      sb_hop_rd;
	logic [CS_W-1:0]       sb_cs_rd;
	logic [SIZE_W-1:0]     sb_size_rd;
	logic [BUS_ADDR_W-1:0] sb_addr_rd;
	logic                  sb_sent_rd;
	logic [STAMP_W-1:0]    stamp_rd;

	// Operation table
	logic [HOP_W-1:0]      cmd_hop;
	logic [CS_W-1:0]       entry_cs;
	logic [CTRL_OP_W-1:0]  ctrl_op;
	logic [CS_W-1:0]       next_cs;
	logic                  cs_issues;
	logic                  cs_done;
	logic                  visit;

	bus_sched_fsm i_bus_sched_fsm (
		.i_clk                 (i_clk),
		.i_rst                 (i_rst),
		.i_disp_cmd_req        (i_disp_cmd_req),
		.i_disp_cmd_data       (i_disp_cmd_data),
		.i_disp_rsp_ack        (i_disp_rsp_ack),
		.i_ctrl_busy           (i_ctrl_busy),
		.i_ctrl_chip_ready     (i_ctrl_chip_ready),
		.i_sb_tag              (sb_tag_rd),
		.i_sb_hop              (sb_hop_rd),
		.i_sb_cs               (sb_cs_rd),
		.i_sb_size             (sb_size_rd),
		.i_sb_addr             (sb_addr_rd),
		.i_sb_sent_status      (sb_sent_rd),
		.i_entry_cs            (entry_cs),
		.i_ctrl_op             (ctrl_op),
		.i_next_cs             (next_cs),
		.i_cs_issues           (cs_issues),
		.i_cs_done             (cs_done),
		.o_disp_cmd_ack        (o_disp_cmd_ack),
		.o_disp_rsp_req        (o_disp_rsp_req),
		.o_disp_rsp_data       (o_disp_rsp_data),
		.o_disp_chip_active    (o_disp_chip_active),
		.o_disp_wr_buffer_rsvd (o_disp_wr_buffer_rsvd),
		.o_disp_rd_buffer_rsvd (o_disp_rd_buffer_rsvd),
		.o_ctrl_operation      (o_ctrl_operation),
		.o_ctrl_chip           (o_ctrl_chip),
		.o_ctrl_addr           (o_ctrl_addr),
		.o_ctrl_length         (o_ctrl_length),
		.o_ctrl_start          (o_ctrl_start),
		.o_sb_index            (sb_index),
		.o_sb_we               (sb_we),
		.o_sb_tag              (sb_tag_wr),
		.o_sb_hop              (sb_hop_wr),
		.o_sb_cs               (sb_cs_wr),
		.o_sb_size             (sb_size_wr),
		.o_sb_addr             (sb_addr_wr),
		.o_sb_sent_status      (sb_sent_wr),
		.o_cmd_hop             (cmd_hop),
		.o_visit               (visit)
	);

	chip_scoreboard i_chip_scoreboard (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_index       (sb_index),
		.i_we          (sb_we),
		.i_tag         (sb_tag_wr),
		.i_hop         (sb_hop_wr),
		.i_cs          (sb_cs_wr),
		.i_size        (sb_size_wr),
		.i_addr        (sb_addr_wr),
		.i_sent_status (sb_sent_wr),
		.i_stamp       (stamp_wr),
		.o_tag         (sb_tag_rd),
		.o_hop         (sb_hop_rd),
		.o_cs          (sb_cs_rd),
		.o_size        (sb_size_rd),
		.o_addr        (sb_addr_rd),
		.o_sent_status (sb_sent_rd),
		.o_stamp       (stamp_rd)
	);

	chip_op_table i_chip_op_table (
		.i_cmd_hop  (cmd_hop),
		.i_cs       (sb_cs_rd),
		.o_entry_cs (entry_cs),
		.o_ctrl_op  (ctrl_op),
		.o_next_cs  (next_cs),
		.o_issues   (cs_issues),
		.o_done     (cs_done)
	);

	cycle_profiler i_cycle_profiler (
		.i_clk              (i_clk),
		.i_rst              (i_rst),
		.i_visit            (visit),
		.i_cs               (sb_cs_rd),
		.i_stamp_rd         (stamp_rd),
		.i_cyclecount_reset (i_cyclecount_reset),
		.i_cyclecount_start (i_cyclecount_start),
		.i_cyclecount_end   (i_cyclecount_end),
		.o_stamp_wr         (stamp_wr),
		.o_cyclecount_sum   (o_cyclecount_sum)
	);

endmodule

/* testbench/flash_bus_sva.sv */
/*
 * Flash bus scheduler assertions on the dispatcher and controller handshakes
 */
`timescale 1ns/1ps

module flash_bus_sva
	import flash_bus_pkg::*;
(
	input logic              i_clk,
	input logic              i_rst,
	input logic              i_disp_rsp_ack,
	input logic              i_ctrl_busy,
	input logic              o_disp_cmd_ack,
	input logic              o_disp_rsp_req,
	input logic [RSLT_W-1:0] o_disp_rsp_data,
	input logic [NUM_CHIPS-1:0] o_disp_chip_active,
	input logic              o_disp_wr_buffer_rsvd,
	input logic              o_disp_rd_buffer_rsvd,
	input logic [SUM_W-1:0]  o_cyclecount_sum,
	input logic              o_ctrl_start
);

	ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
		o_disp_cmd_ack |=> !o_disp_cmd_ack)
		else $error("command ack lasted more than one cycle");

	rsp_held: assert property (@(posedge i_clk) disable iff (i_rst)
		o_disp_rsp_req && !i_disp_rsp_ack |=> o_disp_rsp_req && $stable(o_disp_rsp_data))
		else $error("result request or data changed before the ack");

	start_not_busy: assert property (@(posedge i_clk) disable iff (i_rst)
		!(o_ctrl_start && i_ctrl_busy))
		else $error("controller start while busy");

	reset_quiet: assert property (@(posedge i_clk)
		i_rst |-> !o_disp_cmd_ack && !o_disp_rsp_req && !o_ctrl_start &&
			o_disp_chip_active == '0 && !o_disp_wr_buffer_rsvd &&
			!o_disp_rd_buffer_rsvd && o_cyclecount_sum == '0)
		else $error("outputs active during reset");

endmodule

bind flash_bus_top flash_bus_sva i_flash_bus_sva (.*);

/* testbench/tb_flash_bus.sv */
/*
 * Testbench for the flash bus scheduler with a trace-driven dispatcher and
 * a bus controller model with random busy and ready delays
 */
`timescale 1ns/1ps

module tb_flash_bus
	import flash_bus_pkg::*;
;
	localparam int N_LINES = 12;
	localparam int LIMIT   = 400 * N_LINES;

	logic i_clk;
	logic i_rst;
	logic i_disp_cmd_req;
	logic i_disp_rsp_ack;
	logic i_cyclecount_reset;
	logic i_ctrl_busy;
	logic [CMD_W-1:0] i_disp_cmd_data;
	logic [7:0] i_cyclecount_start;
	logic [7:0] i_cyclecount_end;
	logic [NUM_CHIPS-1:0] i_ctrl_chip_ready;
	logic o_disp_cmd_ack;
	logic o_disp_rsp_req;
	logic o_disp_wr_buffer_rsvd;
	logic o_disp_rd_buffer_rsvd;
	logic [RSLT_W-1:0] o_disp_rsp_data;
	logic [NUM_CHIPS-1:0] o_disp_chip_active;
	logic [SUM_W-1:0] o_cyclecount_sum;
	logic [CTRL_OP_W-1:0] o_ctrl_operation;
	logic [CHIP_W-1:0] o_ctrl_chip;
	logic [FLASH_ADDR_W-1:0] o_ctrl_addr;
	logic [LEN_W-1:0] o_ctrl_length;
	logic o_ctrl_start;

	logic [CMD_W-1:0] trace_mem [0:2*N_LINES-1];
	logic [31:0] lfsr = 32'h275d;
	int chip_cmd [NUM_CHIPS];
	int op_step [NUM_CHIPS];
	bit polled [NUM_CHIPS];
	int ready_cnt [NUM_CHIPS];
	int busy_cnt;
	int done_count;
	int ack_count;
	int cycles;
	bit clr_check;
	int clr_chip;
	logic [HOP_W-1:0] clr_hop;

	flash_bus_top i_flash_bus_top (.*);

	always #10 i_clk = ~i_clk;

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_rslt(input string name, input logic [RSLT_W-1:0] exp,
		input logic [RSLT_W-1:0] act);
		if (exp !== act)
			report_fail($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_ctrl_op(input string name, input logic [CTRL_OP_W-1:0] exp,
		input logic [CTRL_OP_W-1:0] act);
		if (exp !== act)
			report_fail($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input logic [FLASH_ADDR_W-1:0] exp,
		input logic [FLASH_ADDR_W-1:0] act);
		if (exp !== act)
			report_fail($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_len(input string name, input logic [LEN_W-1:0] exp,
		input logic [LEN_W-1:0] act);
		if (exp !== act)
			report_fail($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_sum(input string name, input logic [SUM_W-1:0] exp,
		input logic [SUM_W-1:0] act);
		if (exp !== act)
			report_fail($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
	function automatic int rand_bits(input int n);
		int v;
		logic fb;
		v = 0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = (v << 1) | fb;
		end
		return v;
	endfunction

	function automatic logic [CTRL_OP_W-1:0] expected_op(input logic [HOP_W-1:0] hop,
		input int step);
		if (hop == HOP_READ)
			return (step == 0) ? OP_STARTREAD : OP_COMPLETEREAD;
		return (hop == HOP_PROGRAM) ? OP_PROGRAM : OP_ERASE;
	endfunction

	// Controller model and start checks
	always @(posedge i_clk) begin
		logic [CMD_W-1:0] cmd;
		int c;
		int drop;
		if (!i_rst) begin
			for (int k = 0; k < NUM_CHIPS; k++) begin
				if (ready_cnt[k] != 0) begin
					ready_cnt[k] <= ready_cnt[k] - 1;
					i_ctrl_chip_ready[k] <= (ready_cnt[k] == 1);
				end
			end
			if (busy_cnt != 0)
				busy_cnt <= busy_cnt - 1;
			else
				i_ctrl_busy <= 1'b0;
			if (o_ctrl_start) begin
				c = o_ctrl_chip;
				cmd = trace_mem[2*chip_cmd[c]];
				if (i_ctrl_busy)
					report_fail("Controller started while it was busy");
				if (!o_disp_chip_active[c])
					report_fail("Controller started for a chip with no command");
				check_addr("flash address", cmd[39:0], o_ctrl_addr);
				check_len("length", cmd[63:54] * 32, o_ctrl_length);
				busy_cnt <= 1 + rand_bits(2);
				i_ctrl_busy <= 1'b1;
				if (!i_ctrl_chip_ready[c]) begin
					check_ctrl_op("status poll", polled[c] ? OP_JUSTREADSTATUS : OP_READSTATUS,
						o_ctrl_operation);
					polled[c] = 1'b1;
				end else begin
					check_ctrl_op("bus op", expected_op(cmd[53:46], op_step[c]), o_ctrl_operation);
					op_step[c] = op_step[c] + 1;
					drop = rand_bits(5) % 21;
					ready_cnt[c] <= drop;
					i_ctrl_chip_ready[c] <= (drop == 0);
				end
			end
		end
	end

	// Dispatcher result side
	always @(posedge i_clk) begin
		int idx;
		logic [CMD_W-1:0] cmd;
		if (!i_rst) begin
			if (clr_check) begin
				clr_check <= 1'b0;
				if (o_disp_chip_active[clr_chip])
					report_fail("Chip still active after result ack");
				if ((clr_hop == HOP_READ && o_disp_rd_buffer_rsvd) ||
					(clr_hop == HOP_PROGRAM && o_disp_wr_buffer_rsvd))
					report_fail("Buffer reservation still set after result ack");
			end
			if (o_disp_rsp_req && !i_disp_rsp_ack) begin
				idx = -1;
				for (int k = 0; k < N_LINES; k++)
					if (trace_mem[2*k][71:64] == o_disp_rsp_data[25:18])
						idx = k;
				if (idx < 0)
					report_fail("Result carries a tag that was never sent");
				cmd = trace_mem[2*idx];
				check_rslt($sformatf("result line %0d", idx), trace_mem[2*idx+1][RSLT_W-1:0],
					o_disp_rsp_data);
				if (op_step[cmd[41:40]] != ((cmd[53:46] == HOP_READ) ? 2 : 1))
					report_fail("Result returned before all bus ops were issued");
				clr_chip <= cmd[41:40];
				clr_hop <= cmd[53:46];
				done_count <= done_count + 1;
				i_disp_rsp_ack <= 1'b1;
			end else if (i_disp_rsp_ack) begin
				i_disp_rsp_ack <= 1'b0;
				clr_check <= 1'b1;
			end
		end
	end

	// Ack counting and timeout
	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT)
			report_fail("Timeout waiting for the scheduler to finish the trace");
		if (!i_rst && o_disp_cmd_ack) begin
			if (!i_disp_cmd_req)
				report_fail("Command ack without a pending request");
			ack_count <= ack_count + 1;
		end
	end

	task automatic send_cmd(input int idx);
		logic [CMD_W-1:0] cmd;
		int c;
		cmd = trace_mem[2*idx];
		c = cmd[41:40];
		do @(posedge i_clk);
		while (o_disp_chip_active[c] || clr_check || i_disp_rsp_ack ||
			(cmd[53:46] == HOP_READ && o_disp_rd_buffer_rsvd) ||
			(cmd[53:46] == HOP_PROGRAM && o_disp_wr_buffer_rsvd));
		chip_cmd[c] = idx;
		op_step[c] = 0;
		polled[c] = 1'b0;
		i_disp_cmd_req <= 1'b1;
		i_disp_cmd_data <= cmd;
		do @(posedge i_clk);
		while (!o_disp_cmd_ack);
		i_disp_cmd_req <= 1'b0;
		@(posedge i_clk);
		if (!o_disp_chip_active[c] ||
			(cmd[53:46] == HOP_READ && !o_disp_rd_buffer_rsvd) ||
			(cmd[53:46] == HOP_PROGRAM && !o_disp_wr_buffer_rsvd))
			report_fail("Active bit or buffer reservation not set after command ack");
	endtask

	task automatic wait_done(input int count);
		while (done_count < count || i_disp_rsp_ack || clr_check)
			@(posedge i_clk);
	endtask

	initial begin
		i_clk = 1'b0;
		i_rst = 1'b1;
		i_disp_cmd_req = 1'b0;
		i_disp_cmd_data = '0;
		i_disp_rsp_ack = 1'b0;
		i_cyclecount_reset = 1'b0;
		i_cyclecount_start = 8'd0;
		i_cyclecount_end = 8'd0;
		i_ctrl_busy = 1'b0;
		i_ctrl_chip_ready = '1;
		busy_cnt = 0;
		done_count = 0;
		ack_count = 0;
		cycles = 0;
		clr_check = 1'b0;
		for (int k = 0; k < NUM_CHIPS; k++) begin
			ready_cnt[k] = 0;
			op_step[k] = 0;
		end
		$readmemh("testbench/flash_bus_trace.txt", trace_mem);
		repeat (8) @(posedge i_clk);
		i_rst <= 1'b0;
		// Profiler window off while four chips are kept busy at once
		for (int k = 0; k < 8; k++)
			send_cmd(k);
		wait_done(8);
		check_sum("sum with window off", '0, o_cyclecount_sum);
		// Window from read start pending to read data pending
		i_cyclecount_start <= 8'd1;
		i_cyclecount_end <= 8'd2;
		for (int k = 8; k < N_LINES; k++)
			send_cmd(k);
		wait_done(N_LINES);
		if (o_cyclecount_sum == '0)
			report_fail("Profiler sum stayed zero over READ commands");
		i_cyclecount_reset <= 1'b1;
		@(posedge i_clk);
		i_cyclecount_reset <= 1'b0;
		repeat (2) @(posedge i_clk);
		check_sum("sum after reset", '0, o_cyclecount_sum);
		if (ack_count != N_LINES) begin
			report_fail("Number of command acks differs from number of commands");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

/* flash_bus.f */
verilog/flash_bus_pkg.sv
verilog/chip_scoreboard.sv
verilog/chip_op_table.sv
verilog/cycle_profiler.sv
verilog/bus_sched_fsm.sv
verilog/flash_bus_top.sv
testbench/flash_bus_sva.sv
testbench/tb_flash_bus.sv

/* Bender.yml */
package:
  name: flash_bus

sources:
  - files:
      - verilog/flash_bus_pkg.sv
      - verilog/chip_scoreboard.sv
      - verilog/chip_op_table.sv
      - verilog/cycle_profiler.sv
      - verilog/bus_sched_fsm.sv
      - verilog/flash_bus_top.sv
  - target: test
    files:
      - testbench/flash_bus_sva.sv
      - testbench/tb_flash_bus.sv

/* testbench/flash_bus_trace.txt */
// Columns: command {tag 8, size 10, op 8, addr 46 with chip in 41..40}, expected result
// Lines 0..7 run with the profiler window off, lines 8..11 with start 1 and end 2
010100400000001000 0040400
020200810000020000 0080800
030040c20000400000 00c0100
040040c30000800000 0100100
0504008000000a0040 0141000
060080410000300080 0180200
070800c20001000000 01c2000
08ffc08312345678e0 023ff00
110100410000002000 0440400
120080c00000004000 0480200
130180420000006000 04c0600
140040830000008000 0500100
